//--- all.f
hw/csiVideoPkg.sv
hw/lineMonitor.sv
hw/pixelFifo.sv
hw/wordSplitter.sv
hw/csiVideoTop.sv
verification/csiVideoTb.sv

//--- hw/csiVideoPkg.sv
//--------------------------------------
// CSI-2 video back end definitions
// Widths, buffer depths and the types
// shared along the pixel path
//--------------------------------------
`default_nettype none

package csiVideoPkg;

	//--------------------------------------
	// Widths
	//--------------------------------------
	localparam int lpPixelWordWidth = 64;	// Four packed YUV422 samples
	localparam int lpVideoWidth = 16;		// One sample pair to the sink
	localparam int lpWordsPerPixel = lpPixelWordWidth / lpVideoWidth;

	// Per-line counters, enough for a 4K line at one pixel per clock
	localparam int lpLineCntWidth = 12;

	//--------------------------------------
	// Buffers
	//--------------------------------------
	localparam int lpInFifoDepth = 16;		// Pixel words
	localparam int lpOutFifoDepth = 32;	// Video words

	// Free entries at almost full
	// Covers words still in flight in the splitter
	localparam int lpOutAlmostMargin = 4;

	//--------------------------------------
	// Types
	//--------------------------------------
	typedef logic [lpPixelWordWidth-1:0] tPixelWord;	// Sample 0 in bits 15:0
	typedef logic [lpVideoWidth-1:0] tVideoWord;
	typedef logic [lpLineCntWidth-1:0] tLineCount;		// Cycle or strobe count

	// Splitter FSM
	typedef enum logic [1:0]
	{
		Idle,	// Nothing held
		Fetch,	// Read issued, data due
		Emit	// Word held, slices going out
	} tSplitState;

endpackage

`default_nettype wire

//--- hw/csiVideoTop.sv
//--------------------------------------
// CSI-2 video back end top
// Line monitor, pixel word buffer, word
// splitter and video word buffer
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csiVideoTop
	import csiVideoPkg::*;
(
	input logic iPCLK,
	input logic iSRST,
	// From the CSI-2 controller
	input logic iMipiRxHs,
	input logic iMipiRxVd,
	input tPixelWord iMipiRxPixelData,
	// Video sink
	input logic iVideoFull,
	output tVideoWord oVideoData,
	output logic oVideoVd,
	// Status
	output logic oInFifoFull,
	output tLineCount oHsyncLength,
	output tLineCount oPixelsPerLine
);

	// Pixel word buffer
	logic wInWe;
	logic wInRe;
	tPixelWord wInRd;
	logic wInRvd;
	logic wInEmpty;
	// Video word buffer
	tVideoWord wOutWd;
	logic wOutWe;
	logic wOutAlmostFull;
	logic wOutRe;
	logic wOutEmpty;

	//--------------------------------------
	// Gates
	//--------------------------------------
	assign wInWe = iMipiRxVd & ~oInFifoFull;	// Drop words while full
	assign wOutRe = ~wOutEmpty & ~iVideoFull;	// Sink back-pressure

	lineMonitor uLineMonitor (
		.iPCLK(iPCLK),
		.iSRST(iSRST),
		.iHs(iMipiRxHs),
		.iVd(iMipiRxVd),
		.oHsyncLength(oHsyncLength),
		.oPixelsPerLine(oPixelsPerLine)
	);

	// Margin 0 makes almost full equal to full
	pixelFifo #(
		.pWidth(lpPixelWordWidth),
		.pDepth(lpInFifoDepth),
		.pAlmostMargin(0)
	) uInFifo (
		.iPCLK(iPCLK),
		.iSRST(iSRST),
		.iWd(iMipiRxPixelData),
		.iWe(wInWe),
		.oFull(oInFifoFull),
		.oAlmostFull(),
		.iRe(wInRe),
		.oRd(wInRd),
		.oRvd(wInRvd),
		.oEmpty(wInEmpty)
	);

	wordSplitter uWordSplitter (
		.iPCLK(iPCLK),
		.iSRST(iSRST),
		.oRe(wInRe),
		.iRd(wInRd),
		.iRvd(wInRvd),
		.iEmpty(wInEmpty),
		.oWd(wOutWd),
		.oWe(wOutWe),
		.iAlmostFull(wOutAlmostFull)
	);

	// Splitter holds at almost full and never reaches oFull
	pixelFifo #(
		.pWidth(lpVideoWidth),
		.pDepth(lpOutFifoDepth),
		.pAlmostMargin(lpOutAlmostMargin)
	) uOutFifo (
		.iPCLK(iPCLK),
		.iSRST(iSRST),
		.iWd(wOutWd),
		.iWe(wOutWe),
		.oFull(),
		.oAlmostFull(wOutAlmostFull),
		.iRe(wOutRe),
		.oRd(oVideoData),
		.oRvd(oVideoVd),
		.oEmpty(wOutEmpty)
	);

endmodule

`default_nettype wire

//--- hw/lineMonitor.sv
//--------------------------------------
// Line monitor
// Measures the sync level length and the
// valid words inside each line
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lineMonitor
	import csiVideoPkg::*;
(
	input logic iPCLK,
	input logic iSRST,
	input logic iHs,			// High during a line
	input logic iVd,			// One strobe per word
	output tLineCount oHsyncLength,
	output tLineCount oPixelsPerLine
);

	//--------------------------------------
	// Edge detect
	//--------------------------------------
	logic rHsLast;
	logic wHsFall;
	tLineCount rHsCnt;		// Running sync length
	tLineCount rVdCnt;		// Running strobe count

	assign wHsFall = rHsLast & ~iHs;	// First low cycle after a line

	//--------------------------------------
	// Counters and held results
	//--------------------------------------
	always_ff @(posedge iPCLK)
	begin
		if (iSRST)
		begin
			rHsLast <= 1'b0;
			rHsCnt <= '0;
			rVdCnt <= '0;
			oHsyncLength <= '0;
			oPixelsPerLine <= '0;
		end
		else
		begin
			rHsLast <= iHs;

			if (wHsFall)
			begin
				// Line done, publish and restart
				oHsyncLength <= rHsCnt;
				oPixelsPerLine <= rVdCnt;
				rHsCnt <= '0;
				rVdCnt <= '0;
			end
			else if (iHs)
			begin
				if (rHsCnt != '1)
					rHsCnt <= rHsCnt + 1'b1;	// Saturate at max
				if (iVd && (rVdCnt != '1))
					rVdCnt <= rVdCnt + 1'b1;
			end
		end
	end

	// Held results move only right after a line ends, or out of reset
	aHeldStable: assert property (@(posedge iPCLK) disable iff (iSRST)
		((oHsyncLength != $past(oHsyncLength)) ||
			(oPixelsPerLine != $past(oPixelsPerLine)))
		|-> ($past(wHsFall) || $past(iSRST)));

endmodule

`default_nettype wire

//--- hw/pixelFifo.sv
//--------------------------------------
// Single-clock FIFO
// Circular buffer with a registered read
// port and an almost-full flag
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixelFifo
	import csiVideoPkg::*;
#(
	parameter int pWidth = lpVideoWidth,
	parameter int pDepth = lpOutFifoDepth,
	parameter int pAlmostMargin = lpOutAlmostMargin	// Free entries at almost full
)(
	input logic iPCLK,
	input logic iSRST,
	// Write side
	input logic [pWidth-1:0] iWd,
	input logic iWe,
	output logic oFull,
	output logic oAlmostFull,
	// Read side
	input logic iRe,
	output logic [pWidth-1:0] oRd,
	output logic oRvd,			// Data valid one cycle after iRe
	output logic oEmpty
);

	localparam int lpAddrWidth = (pDepth > 1) ? $clog2(pDepth) : 1;
	localparam int lpCntWidth = $clog2(pDepth + 1);

	//--------------------------------------
	// Storage and pointers
	//--------------------------------------
	logic [pWidth-1:0] rMem [pDepth];
	logic [lpAddrWidth-1:0] rWrPtr;
	logic [lpAddrWidth-1:0] rRdPtr;
	logic [lpCntWidth-1:0] rCount;		// Occupancy
	logic wWrite;
	logic wRead;

	assign wWrite = iWe & ~oFull;		// Guard against overrun
	assign wRead = iRe & ~oEmpty;

	// Flags straight from occupancy
	assign oFull = (rCount == lpCntWidth'(pDepth));
	assign oEmpty = (rCount == '0);
	assign oAlmostFull = ((lpCntWidth'(pDepth) - rCount) <= lpCntWidth'(pAlmostMargin));

	// Data array
	always_ff @(posedge iPCLK)
	begin
		if (wWrite)
			rMem[rWrPtr] <= iWd;
		if (wRead)
			oRd <= rMem[rRdPtr];	// Registered read
	end

	// Control state
	always_ff @(posedge iPCLK)
	begin
		if (iSRST)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
			oRvd <= 1'b0;
		end
		else
		begin
			oRvd <= wRead;

			if (wWrite)
				rWrPtr <= (rWrPtr == lpAddrWidth'(pDepth - 1)) ? '0 : rWrPtr + 1'b1;
			if (wRead)
				rRdPtr <= (rRdPtr == lpAddrWidth'(pDepth - 1)) ? '0 : rRdPtr + 1'b1;

			case ({wWrite, wRead})
				2'b10: rCount <= rCount + 1'b1;
				2'b01: rCount <= rCount - 1'b1;
				default: rCount <= rCount;	// Idle or both at once
			endcase
		end
	end

	//--------------------------------------
	// Caller gating
	//--------------------------------------
	aNoWriteFull: assert property (@(posedge iPCLK) disable iff (iSRST)
		iWe |-> !oFull);
	aNoReadEmpty: assert property (@(posedge iPCLK) disable iff (iSRST)
		iRe |-> !oEmpty);

endmodule

`default_nettype wire

//--- hw/wordSplitter.sv
//--------------------------------------
// Word splitter
// Unpacks each 64-bit pixel word into
// four 16-bit video words, low first
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wordSplitter
	import csiVideoPkg::*;
(
	input logic iPCLK,
	input logic iSRST,
	// Pixel word FIFO
	output logic oRe,
	input tPixelWord iRd,
	input logic iRvd,
	input logic iEmpty,
	// Video word FIFO
	output tVideoWord oWd,
	output logic oWe,
	input logic iAlmostFull
);

	localparam int lpSliceWidth = $clog2(lpWordsPerPixel);

	tSplitState rState;
	tPixelWord rHold;				// Word being emitted
	logic [lpSliceWidth-1:0] rSlice;	// Next slice to send
	logic wLastSlice;
	tPixelWord qEmitSrc;
	logic qRe;
	logic qWe;

	assign wLastSlice = (rSlice == lpSliceWidth'(lpWordsPerPixel - 1));

	//--------------------------------------
	// Read, emit and source select
	//--------------------------------------
	always_comb
	begin
		qRe = 1'b0;
		qWe = 1'b0;
		qEmitSrc = rHold;
		case (rState)
			Idle:
				qRe = ~iEmpty;			// Start a fetch
			Fetch:
			begin
				// Slice 0 goes out straight from the read port
				qEmitSrc = iRd;
				qWe = iRvd & ~iAlmostFull;
			end
			Emit:
			begin
				qWe = ~iAlmostFull;
				qRe = qWe & wLastSlice & ~iEmpty;	// Prefetch on last slice
			end
			default:
				qRe = 1'b0;
		endcase
	end

	assign oRe = qRe;
	assign oWe = qWe;
	assign oWd = qEmitSrc[rSlice*lpVideoWidth +: lpVideoWidth];

	//--------------------------------------
	// FSM
	//--------------------------------------
	always_ff @(posedge iPCLK)
	begin
		if (iSRST)
		begin
			rState <= Idle;
			rSlice <= '0;
		end
		else
		begin
			if (qWe)
				rSlice <= rSlice + 1'b1;	// Wraps to 0 after the last slice

			case (rState)
				Idle:
					if (qRe)
						rState <= Fetch;
				Fetch:
					if (iRvd)
						rState <= Emit;
				Emit:
					if (qWe && wLastSlice)
						rState <= qRe ? Fetch : Idle;
				default:
					rState <= Idle;
			endcase
		end
	end

	// Capture the fetched word
	always_ff @(posedge iPCLK)
	begin
		if ((rState == Fetch) && iRvd)
			rHold <= iRd;
	end

	// Read only from a non-empty FIFO with data back one cycle later
	aReadReturns: assert property (@(posedge iPCLK) disable iff (iSRST)
		oRe |-> !iEmpty ##1 iRvd);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the CSI-2 video back end testbench with Verilator,
# runs it and judges the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=csiVideoSim

verilator --binary --timing --assert -j 0 \
	-f all.f \
	--top-module csiVideoTb \
	-o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0

//--- verification/csiVideoTb.sv
//--------------------------------------
// CSI-2 video back end testbench
// Random pixel lines against a reference
// queue, sink stalls, overflow and line
// measurement, checked by assertions
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module csiVideoTb
	import csiVideoPkg::*;
();

	localparam int lpResetCycles = 8;
	// Expected test lengths in cycles
	localparam int lpResetLen = 20;
	localparam int lpOrderLen = 300;
	localparam int lpBackLen = 600;
	localparam int lpOverLen = 600;
	localparam int lpLineLen = 800;
	localparam int lpTimeout =
		2 * (lpResetLen + lpOrderLen + lpBackLen + lpOverLen + lpLineLen);

	logic iPCLK;
	logic iSRST;
	logic iMipiRxHs;
	logic iMipiRxVd;
	tPixelWord iMipiRxPixelData;
	logic iVideoFull;
	tVideoWord oVideoData;
	logic oVideoVd;
	logic oInFifoFull;
	tLineCount oHsyncLength;
	tLineCount oPixelsPerLine;

	integer seed;
	int errCount = 0;
	int testCount = 0;
	int testsPassed = 0;
	int cycleCnt = 0;
	int fullMode = 0;			// 0 sink ready, 1 random stalls, 2 sink full
	logic sawInFull = 1'b0;
	tVideoWord refQ[$];			// Expected video words, oldest first
	tVideoWord expHead = '0;
	int refCount = 0;
	tLineCount expH = '0;		// Sync length of the last line sent
	tLineCount expP = '0;		// Strobes in the last line sent

	csiVideoTop u_dut (
		.iPCLK(iPCLK),
		.iSRST(iSRST),
		.iMipiRxHs(iMipiRxHs),
		.iMipiRxVd(iMipiRxVd),
		.iMipiRxPixelData(iMipiRxPixelData),
		.iVideoFull(iVideoFull),
		.oVideoData(oVideoData),
		.oVideoVd(oVideoVd),
		.oInFifoFull(oInFifoFull),
		.oHsyncLength(oHsyncLength),
		.oPixelsPerLine(oPixelsPerLine)
	);

	//--------------------------------------
	// Clock and run limit
	//--------------------------------------
	initial
	begin
		iPCLK = 1'b0;
		forever #50 iPCLK = ~iPCLK;		// 100 ns period
	end

	always @(posedge iPCLK)
		cycleCnt <= cycleCnt + 1;

	initial
	begin
		wait (cycleCnt >= lpTimeout);
		$display("Timeout after %0d cycles, the DUT stopped draining its output", cycleCnt);
		$display("Test FAILED");
		$finish;
	end

	//--------------------------------------
	// Reference queue
	//--------------------------------------
	always @(posedge iPCLK)
	begin
		if (iSRST)
			refQ.delete();
		else
		begin
			if (oVideoVd && (refQ.size() > 0))
				void'(refQ.pop_front());	// Word leaves the DUT
			if (iMipiRxVd && !oInFifoFull)
			begin
				// Accepted word goes in lowest sample first
				for (int i = 0; i < lpWordsPerPixel; i++)
					refQ.push_back(iMipiRxPixelData[i*lpVideoWidth +: lpVideoWidth]);
			end
			if (oInFifoFull)
				sawInFull = 1'b1;
		end
		refCount = refQ.size();
		expHead = (refQ.size() > 0) ? refQ[0] : '0;
	end

	//--------------------------------------
	// Assertions
	//--------------------------------------
	aResetQuiet: assert property (@(posedge iPCLK) $fell(iSRST) |->
		(!oVideoVd && !oInFifoFull && (oHsyncLength == '0) && (oPixelsPerLine == '0)))
	else
	begin
		errCount++;
		$write("CHECK FAILED reset outputs oVideoVd=%h oInFifoFull=%h",
			$sampled(oVideoVd), $sampled(oInFifoFull));
		$display(" oHsyncLength=%h oPixelsPerLine=%h, expected all 0",
			$sampled(oHsyncLength), $sampled(oPixelsPerLine));
	end

	aNoExtraWord: assert property (@(posedge iPCLK) disable iff (iSRST)
		oVideoVd |-> (refCount > 0))
	else
	begin
		errCount++;
		$display("Video word %h came out with nothing left to expect", $sampled(oVideoData));
	end

	aWordMatch: assert property (@(posedge iPCLK) disable iff (iSRST)
		(oVideoVd && (refCount > 0)) |-> (oVideoData == expHead))
	else
	begin
		errCount++;
		$display("CHECK FAILED oVideoData expected %h got %h",
			$sampled(expHead), $sampled(oVideoData));
	end

	// Sink full blocks the next word
	aStallHolds: assert property (@(posedge iPCLK) disable iff (iSRST)
		iVideoFull |=> !oVideoVd)
	else
	begin
		errCount++;
		$display("CHECK FAILED oVideoVd expected 0 got %h after iVideoFull", $sampled(oVideoVd));
	end

	aSyncLength: assert property (@(posedge iPCLK) disable iff (iSRST)
		$fell(iMipiRxHs) |=> (oHsyncLength == expH))
	else
	begin
		errCount++;
		$display("CHECK FAILED oHsyncLength expected %h got %h",
			$sampled(expH), $sampled(oHsyncLength));
	end

	aPixelCount: assert property (@(posedge iPCLK) disable iff (iSRST)
		$fell(iMipiRxHs) |=> (oPixelsPerLine == expP))
	else
	begin
		errCount++;
		$display("CHECK FAILED oPixelsPerLine expected %h got %h",
			$sampled(expP), $sampled(oPixelsPerLine));
	end

	//--------------------------------------
	// Stimulus helpers
	//--------------------------------------
	task automatic nextCycle();
		@(posedge iPCLK);
		#1;			// Drive just after the edge
		// Sink full level
		case (fullMode)
			1: iVideoFull = (({$random(seed)} % 2) == 1);
			2: iVideoFull = 1'b1;
			default: iVideoFull = 1'b0;
		endcase
	endtask

	// One line of random words with idle gaps between strobes
	task automatic sendLine(input int nWords, input int idleMin, input int idleSpan);
		int hLen;
		int idle;
		hLen = 0;
		for (int w = 0; w < nWords; w++)
		begin
			idle = idleMin;
			if (idleSpan > 0)
				idle = idleMin + int'({$random(seed)} % idleSpan);
			repeat (idle)
			begin
				iMipiRxHs = 1'b1;
				iMipiRxVd = 1'b0;
				nextCycle();
				hLen++;
			end
			iMipiRxHs = 1'b1;
			iMipiRxVd = 1'b1;
			iMipiRxPixelData = {$random(seed), $random(seed)};
			nextCycle();
			hLen++;
		end
		iMipiRxVd = 1'b0;		// Trailing high cycle
		nextCycle();
		hLen++;
		expH = tLineCount'(hLen);
		expP = tLineCount'(nWords);
		iMipiRxHs = 1'b0;
		repeat (3)
			nextCycle();	// Line gap
	endtask

	task automatic drainOutput();
		while (refCount != 0)
			nextCycle();
		// Extra cycles so a stray word still hits aNoExtraWord
		repeat (8)
			nextCycle();
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
		begin
			testsPassed++;
			$display("%s: passed", name);
		end
		else
			$display("%s: failed with %0d errors", name, errCount - errBefore);
	endtask

	//--------------------------------------
	// Test sequence
	//--------------------------------------
	initial
	begin
		int errBefore;
		int nWords;
		seed = 32'h7b39_2866;
		iSRST = 1'b1;
		iMipiRxHs = 1'b0;
		iMipiRxVd = 1'b0;
		iMipiRxPixelData = '0;
		iVideoFull = 1'b0;
		repeat (lpResetCycles)
			@(posedge iPCLK);
		#1;
		iSRST = 1'b0;

		errBefore = errCount;
		nextCycle();
		nextCycle();	// aResetQuiet fires here
		reportTest("reset", errBefore);

		// Word rate kept below the splitter rate
		errBefore = errCount;
		sendLine(24, 3, 3);
		drainOutput();
		reportTest("order and content", errBefore);

		errBefore = errCount;
		fullMode = 1;
		sendLine(32, 8, 4);
		drainOutput();
		fullMode = 0;
		reportTest("back-pressure", errBefore);

		errBefore = errCount;
		sawInFull = 1'b0;
		fullMode = 2;
		sendLine(60, 0, 0);
		fullMode = 0;
		drainOutput();
		assert (sawInFull)
		else
		begin
			errCount++;
			$display("Overflow test: the input FIFO never reported full");
		end
		reportTest("overflow", errBefore);

		errBefore = errCount;
		repeat (5)
		begin
			nWords = 4 + int'({$random(seed)} % 12);
			sendLine(nWords, 0, 3);
		end
		drainOutput();
		reportTest("line measurement", errBefore);

		$display("Summary: %0d of %0d tests passed, %0d failed checks",
			testsPassed, testCount, errCount);
		if (errCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
